// File: tb.f
+incdir+design
design/sdtx_pkg.sv
design/sdtx_framer.sv
design/sdtx_crc.sv
design/sdtx_serializer.sv
design/sdtx_top.sv
tests/tb_clock.sv
tests/sdtx_tb.sv

// File: tests/sdtx_tb.sv
`timescale 1ns/1ns
`include "sdtx_defines.svh"

module sdtx_tb;
	import sdtx_pkg::*;

	// All tests together stay below a few thousand cycles
	localparam int TIMEOUT_CYCLES = 20000;

	logic                   i_clk;
	logic                   i_reset, i_en, i_ckstb, i_s_valid, i_s_last;
	bus_width_t             i_cfg_width;
	sd_word_t               i_s_data;
	logic                   o_s_ready, o_tx_valid;
	logic [`SDTX_LANES-1:0] o_tx_data;

	int                     errors, frames_done, cycles, seed, sym_idx;
	bit                     mon_on, stb_random;
	string                  test_name;
	sd_word_t               blk [0:7];
	logic [`SDTX_LANES-1:0] exp_q [$];
	logic                   prev_valid, prev_stb;
	logic [`SDTX_LANES-1:0] prev_data;

	tb_clock clock_gen (.o_clk(i_clk));

	sdtx_top sdtx_top_inst (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cfg_width (i_cfg_width),
		.i_en        (i_en),
		.i_ckstb     (i_ckstb),
		.i_s_valid   (i_s_valid),
		.o_s_ready   (o_s_ready),
		.i_s_data    (i_s_data),
		.i_s_last    (i_s_last),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data)
	);

	task automatic check_symbol(input string what, input logic [`SDTX_LANES-1:0] exp,
		input logic [`SDTX_LANES-1:0] act);
		if (act !== exp) begin
			$display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge i_clk);
		#2;
	endtask

	// Strobe every cycle, or half the cycles at random
	always @(posedge i_clk) begin
		#2;
		i_ckstb = stb_random ? ($urandom_range(1, 0) != 0) : 1'b1;
	end

	////////////////////
	// Reference model
	function automatic logic [15:0] crc16_bit(input logic [15:0] crc, input logic din);
		logic fb;
		fb = crc[15] ^ din;
		crc16_bit = {crc[14:0], 1'b0} ^ (fb ? `SDTX_CRC_POLY : 16'h0000);
	endfunction

	task automatic build_expected(input bus_width_t width, input int n);
		logic [15:0] lane_crc [0:3];
		exp_q.delete();
		for (int k = 0; k < 4; k++)
			lane_crc[k] = 16'h0000;
		exp_q.push_back((width == BUS_1W) ? 4'b1110 : 4'b0000);
		if (width == BUS_1W) begin
			for (int w = 0; w < n; w++)
				for (int b = 31; b >= 0; b--) begin
					exp_q.push_back({3'b111, blk[w].bits[b]});
					lane_crc[0] = crc16_bit(lane_crc[0], blk[w].bits[b]);
				end
			for (int i = 15; i >= 0; i--)
				exp_q.push_back({3'b111, lane_crc[0][i]});
		end else begin
			for (int w = 0; w < n; w++)
				for (int p = 7; p >= 0; p--)
					exp_q.push_back(blk[w].bits[4*p +: 4]);
			// Lane k carries bit k of every nibble
			for (int k = 0; k < 4; k++)
				for (int w = 0; w < n; w++)
					for (int p = 7; p >= 0; p--)
						lane_crc[k] = crc16_bit(lane_crc[k], blk[w].bits[4*p+k]);
			for (int i = 15; i >= 0; i--)
				exp_q.push_back({lane_crc[3][i], lane_crc[2][i], lane_crc[1][i], lane_crc[0][i]});
		end
		exp_q.push_back(4'b1111);
	endtask

	////////////////////
	// Frame monitor
	always @(negedge i_clk) begin
		if (mon_on) begin
			if (o_tx_valid && (!prev_valid || prev_stb)) begin
				if (!prev_valid)
					sym_idx = 0;
				if (exp_q.size() == 0) begin
					$display("Error in %s: symbol %0d sent beyond the expected frame",
						test_name, sym_idx);
					errors++;
				end else
					check_symbol($sformatf("symbol %0d", sym_idx), exp_q.pop_front(), o_tx_data);
				sym_idx++;
			end else if (o_tx_valid) begin
				// No strobe, no change
				check_symbol("held symbol", prev_data, o_tx_data);
			end else begin
				if (prev_valid) begin
					if (exp_q.size() != 0) begin
						$display("Error in %s: frame ended with %0d symbols not sent",
							test_name, exp_q.size());
						errors++;
					end
					frames_done++;
				end
				check_symbol("idle level", 4'hf, o_tx_data);
			end
		end
		prev_valid = o_tx_valid;
		prev_stb   = i_ckstb;
		prev_data  = o_tx_data;
	end

	task automatic run_frame(input bus_width_t width, input int n, input bit gaps,
		input bus_width_t later_width, input int hold_off);
		int idx;
		int done_before;
		i_s_valid   = 1'b0;
		i_cfg_width = width;
		i_en        = (hold_off == 0);
		stb_random  = gaps;
		repeat (4) next_cycle();
		for (int w = 0; w < n; w++)
			blk[w].bits = $urandom();
		build_expected(width, n);
		done_before = frames_done;
		i_s_valid   = 1'b1;
		i_s_data    = blk[0];
		i_s_last    = (n == 1);
		repeat (hold_off) begin
			@(negedge i_clk);
			check_flag("s_ready while disabled", 1'b0, o_s_ready);
			check_flag("tx_valid while disabled", 1'b0, o_tx_valid);
			next_cycle();
		end
		i_en = 1'b1;
		idx  = 0;
		while (idx < n) begin
			@(negedge i_clk);
			if (o_s_ready)
				idx++;
			next_cycle();
			if (idx < n) begin
				i_s_data = blk[idx];
				i_s_last = (idx == n - 1);
			end else begin
				i_s_valid = 1'b0;
				i_s_last  = 1'b0;
				// Frame still running, must keep its width
				i_cfg_width = later_width;
			end
		end
		while (frames_done == done_before)
			next_cycle();
		next_cycle();
	endtask

	////////////////////
	// Directed tests
	task automatic after_reset();
		test_name = "after_reset";
		repeat (2) begin
			@(negedge i_clk);
			check_flag("tx_valid", 1'b0, o_tx_valid);
			check_flag("s_ready", 1'b0, o_s_ready);
			check_symbol("idle data", 4'hf, o_tx_data);
		end
		next_cycle();
	endtask

	task automatic single_word_1w();
		test_name = "single_word_1w";
		run_frame(BUS_1W, 1, 1'b0, BUS_1W, 0);
	endtask

	task automatic gapped_block_1w();
		test_name = "gapped_block_1w";
		run_frame(BUS_1W, 8, 1'b1, BUS_1W, 0);
	endtask

	task automatic block_4w();
		test_name = "block_4w";
		run_frame(BUS_4W, 3, 1'b0, BUS_4W, 0);
		run_frame(BUS_4W, 6, 1'b1, BUS_4W, 0);
	endtask

	task automatic width_switch();
		test_name = "width_switch";
		run_frame(BUS_1W, 3, 1'b1, BUS_4W, 0);
		run_frame(BUS_4W, 2, 1'b0, BUS_1W, 0);
		run_frame(BUS_1W, 2, 1'b0, BUS_1W, 0);
		run_frame(BUS_4W, 4, 1'b1, BUS_4W, 0);
	endtask

	task automatic enable_hold();
		test_name = "enable_hold";
		run_frame(BUS_4W, 2, 1'b1, BUS_4W, 6);
		run_frame(BUS_1W, 1, 1'b0, BUS_1W, 4);
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, frame never finished, %0d errors", cycles, errors);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		i_reset     = 1'b1;
		i_en        = 1'b0;
		i_ckstb     = 1'b1;
		i_s_valid   = 1'b0;
		i_s_last    = 1'b0;
		i_s_data    = '0;
		i_cfg_width = BUS_1W;
		stb_random  = 1'b0;
		mon_on      = 1'b0;
		errors      = 0;
		frames_done = 0;
		prev_valid  = 1'b0;
		prev_stb    = 1'b0;
		prev_data   = 4'hf;
		test_name   = "reset";
		seed        = $urandom(53430);
		repeat (3) @(posedge i_clk);
		#2;
		i_reset = 1'b0;
		mon_on  = 1'b1;
		after_reset();
		single_word_1w();
		gapped_block_1w();
		block_4w();
		width_switch();
		enable_hold();
		$display("Run finished: %0d errors over %0d frames", errors, frames_done);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic o_clk
);

	// Free running, starts low
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

endmodule

// File: design/sdtx_top.sv
`timescale 1ns/1ns
`include "sdtx_defines.svh"

module sdtx_top (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  sdtx_pkg::bus_width_t   i_cfg_width,
	input  logic                   i_en,
	input  logic                   i_ckstb,
	input  logic                   i_s_valid,
	output logic                   o_s_ready,
	input  sdtx_pkg::sd_word_t     i_s_data,
	input  logic                   i_s_last,
	output logic                   o_tx_valid,
	output logic [`SDTX_LANES-1:0] o_tx_data
);
	import sdtx_pkg::*;

	crc_ctl_t   crc_ctl;
	sd_word_t   crc_word;
	bus_width_t width;
	tx_word_t   tx_word;
	logic       word_ready;
	logic       tx_busy;

	// Decode
	sdtx_framer u_framer (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_cfg_width  (i_cfg_width),
		.i_en         (i_en),
		.i_s_valid    (i_s_valid),
		.i_s_data     (i_s_data),
		.i_s_last     (i_s_last),
		.o_s_ready    (o_s_ready),
		.i_word_ready (word_ready),
		.i_tx_busy    (tx_busy),
		.i_crc_word   (crc_word),
		.o_crc_ctl    (crc_ctl),
		.o_width      (width),
		.o_tx_word    (tx_word)
	);

	// Execute
	sdtx_crc u_crc (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_width    (width),
		.i_ctl      (crc_ctl),
		.i_data     (i_s_data),
		.o_crc_word (crc_word)
	);

	// Result
	sdtx_serializer u_serializer (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_ckstb      (i_ckstb),
		.i_width      (width),
		.i_tx_word    (tx_word),
		.o_word_ready (word_ready),
		.o_tx_busy    (tx_busy),
		.o_tx_valid   (o_tx_valid),
		.o_tx_data    (o_tx_data)
	);

endmodule

// File: design/sdtx_serializer.sv
`timescale 1ns/1ns
`include "sdtx_defines.svh"

module sdtx_serializer (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_ckstb,
	input  sdtx_pkg::bus_width_t   i_width,
	input  sdtx_pkg::tx_word_t     i_tx_word,
	output logic                   o_word_ready,
	output logic                   o_tx_busy,
	output logic                   o_tx_valid,
	output logic [`SDTX_LANES-1:0] o_tx_data
);
	import sdtx_pkg::*;

	localparam int WORD_W = `SDTX_WORD_W;
	localparam int LANES  = `SDTX_LANES;
	localparam int CNT_W  = $clog2(`SDTX_SYM_1W);

	localparam logic [CNT_W-1:0] CNT_1W  = CNT_W'(`SDTX_SYM_1W - 1);
	localparam logic [CNT_W-1:0] CNT_CRC = CNT_W'(`SDTX_SYM_CRC1W - 1);
	localparam logic [CNT_W-1:0] CNT_4W  = CNT_W'(`SDTX_SYM_4W - 1);

	logic [CNT_W-1:0] count;
	logic             tx_valid;
	logic             stop_pend;
	sd_word_t         sreg;
	logic [LANES-1:0] sym;

	assign o_word_ready = i_ckstb && (count == '0);

	// Valid stays up one symbol past the last word for the stop bit
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			tx_valid  <= 1'b0;
			stop_pend <= 1'b0;
		end else if (i_tx_word.start) begin
			tx_valid  <= 1'b1;
			stop_pend <= 1'b1;
		end else if (o_word_ready) begin
			tx_valid  <= i_tx_word.valid || stop_pend;
			stop_pend <= i_tx_word.valid;
		end
	end

	////////////////////
	// Shift register
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			count <= '0;
			sym   <= '1;
		end else if (o_word_ready && i_tx_word.valid) begin
			if (i_width == BUS_1W) begin
				sreg.bits <= {i_tx_word.data.bits[WORD_W-2:0], 1'b1};
				sym       <= {{(LANES-1){1'b1}}, i_tx_word.data.bits[WORD_W-1]};
				count     <= i_tx_word.short ? CNT_CRC : CNT_1W;
			end else begin
				sreg.bits <= {i_tx_word.data.bits[WORD_W-LANES-1:0], {LANES{1'b1}}};
				sym       <= i_tx_word.data.nib[WORD_W/LANES-1];
				count     <= CNT_4W;
			end
		end else if (i_ckstb && count != '0) begin
			count <= count - 1'b1;
			if (i_width == BUS_1W) begin
				sreg.bits <= {sreg.bits[WORD_W-2:0], 1'b1};
				sym       <= {{(LANES-1){1'b1}}, sreg.bits[WORD_W-1]};
			end else begin
				sreg.bits <= {sreg.bits[WORD_W-LANES-1:0], {LANES{1'b1}}};
				sym       <= sreg.nib[WORD_W/LANES-1];
			end
		end else if (o_word_ready) begin
			// Nothing to send, idle high or drive the start bit
			sreg.bits <= '1;
			if (i_tx_word.start)
				sym <= (i_width == BUS_1W) ? {{(LANES-1){1'b1}}, 1'b0} : '0;
			else
				sym <= '1;
		end
	end

	assign o_tx_valid = tx_valid;
	assign o_tx_busy  = tx_valid;
	assign o_tx_data  = sym;

	a_count_range: assert property (@(posedge i_clk) disable iff (i_reset)
		count <= ((i_width == BUS_1W) ? CNT_1W : CNT_4W));

	// Unused lines stay high on one-line frames
	a_upper_lanes_high: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_width == BUS_1W) |-> (&o_tx_data[LANES-1:1]));

endmodule

// File: design/sdtx_crc.sv
`timescale 1ns/1ns
`include "sdtx_defines.svh"

module sdtx_crc (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  sdtx_pkg::bus_width_t i_width,
	input  sdtx_pkg::crc_ctl_t   i_ctl,
	input  sdtx_pkg::sd_word_t   i_data,
	output sdtx_pkg::sd_word_t   o_crc_word
);
	import sdtx_pkg::*;

	localparam int CRC_W  = `SDTX_CRC_W;
	localparam int WORD_W = `SDTX_WORD_W;
	localparam int LANES  = `SDTX_LANES;
	localparam int NIBS   = WORD_W / LANES;

	logic [CRC_W-1:0]       crc1;
	logic [CRC_W-1:0]       crc1_next;
	// Bit i of lane k sits at i*LANES+k, so the top nibble is bit 15 of every lane
	logic [LANES*CRC_W-1:0] crc4;
	logic [LANES*CRC_W-1:0] crc4_next;

	function automatic logic [CRC_W-1:0] crc_step(input logic [CRC_W-1:0] prior,
		input logic din);
		logic [CRC_W-1:0] shifted;
		shifted = {prior[CRC_W-2:0], 1'b0};
		if (prior[CRC_W-1] ^ din)
			crc_step = shifted ^ `SDTX_CRC_POLY;
		else
			crc_step = shifted;
	endfunction

	// One line, all 32 bits MSB first
	always_comb begin
		crc1_next = crc1;
		for (int b = WORD_W - 1; b >= 0; b--)
			crc1_next = crc_step(crc1_next, i_data.bits[b]);
	end

	////////////////////
	// Four lines
	// Lane k takes bit k of each nibble, upper nibble first
	always_comb begin
		logic [CRC_W-1:0] lane;
		crc4_next = crc4;
		for (int k = 0; k < LANES; k++) begin
			for (int i = 0; i < CRC_W; i++)
				lane[i] = crc4[i*LANES+k];
			for (int n = NIBS - 1; n >= 0; n--)
				lane = crc_step(lane, i_data.nib[n][k]);
			for (int i = 0; i < CRC_W; i++)
				crc4_next[i*LANES+k] = lane[i];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset || i_ctl.clear) begin
			crc1 <= '0;
			crc4 <= '0;
		end else if (i_ctl.load) begin
			if (i_width == BUS_1W)
				crc1 <= crc1_next;
			else
				crc4 <= crc4_next;
		end else if (i_ctl.shift) begin
			crc1 <= '1;
			// Next word moves up, ones fill in behind
			crc4 <= {crc4[LANES*CRC_W-WORD_W-1:0], {WORD_W{1'b1}}};
		end
	end

	// Single-line CRC in the upper half, idle ones below
	assign o_crc_word.bits = (i_width == BUS_1W) ?
		{crc1, {(WORD_W-CRC_W){1'b1}}} : crc4[LANES*CRC_W-1 -: WORD_W];

endmodule

// File: design/sdtx_framer.sv
`timescale 1ns/1ns
`include "sdtx_defines.svh"

module sdtx_framer (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  sdtx_pkg::bus_width_t i_cfg_width,
	input  logic                 i_en,
	input  logic                 i_s_valid,
	input  sdtx_pkg::sd_word_t   i_s_data,
	input  logic                 i_s_last,
	output logic                 o_s_ready,
	input  logic                 i_word_ready,
	input  logic                 i_tx_busy,
	input  sdtx_pkg::sd_word_t   i_crc_word,
	output sdtx_pkg::crc_ctl_t   o_crc_ctl,
	output sdtx_pkg::bus_width_t o_width,
	output sdtx_pkg::tx_word_t   o_tx_word
);
	import sdtx_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_CRC,
		ST_LAST
	} frame_state_t;

	frame_state_t state;
	bus_width_t   cfg_width;
	logic         crc_left;
	logic         start;
	logic         take;
	logic         pend_valid;
	logic         pend_short;
	sd_word_t     pend_data;

	assign start = (state == ST_IDLE) && i_en && i_s_valid && i_word_ready && !i_tx_busy;
	assign o_s_ready = i_word_ready &&
		((state == ST_DATA) || ((state == ST_IDLE) && i_en && !i_tx_busy));
	assign take = i_s_valid && o_s_ready;

	// Width is frozen from the start cycle until the frame is done
	always_ff @(posedge i_clk) begin
		if (i_reset)
			cfg_width <= BUS_1W;
		else if (state == ST_IDLE && !start)
			cfg_width <= i_cfg_width;
	end

	////////////////////
	// Frame FSM
	// Block must arrive without gaps once the frame has started
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state      <= ST_IDLE;
			pend_valid <= 1'b0;
			pend_short <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				pend_valid <= 1'b0;
				pend_short <= 1'b0;
				if (start) begin
					pend_valid <= 1'b1;
					state      <= i_s_last ? ST_CRC : ST_DATA;
				end
			end
			ST_DATA: begin
				if (take && i_s_last)
					state <= ST_CRC;
			end
			ST_CRC: begin
				if (i_word_ready) begin
					pend_short <= (cfg_width == BUS_1W);
					if (!crc_left)
						state <= ST_LAST;
				end
			end
			default: begin
				// Last CRC word handed over, wait for the stop bit
				if (i_word_ready) begin
					pend_valid <= 1'b0;
					pend_short <= 1'b0;
				end
				if (!i_tx_busy)
					state <= ST_IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (take)
			pend_data <= i_s_data;
		else if (i_word_ready && state == ST_CRC)
			pend_data <= i_crc_word;
	end

	// Second CRC word only on four lines
	always_ff @(posedge i_clk) begin
		if (i_reset)
			crc_left <= 1'b0;
		else if (state == ST_IDLE || state == ST_DATA)
			crc_left <= (cfg_width == BUS_4W);
		else if (state == ST_CRC && i_word_ready)
			crc_left <= 1'b0;
	end

	assign o_crc_ctl.load  = take;
	assign o_crc_ctl.shift = i_word_ready && (state == ST_CRC || state == ST_LAST);
	// CRC held at zero whenever the line is idle
	assign o_crc_ctl.clear = !take && !i_tx_busy;

	assign o_tx_word.valid = pend_valid;
	assign o_tx_word.data  = pend_data;
	assign o_tx_word.short = pend_short;
	assign o_tx_word.start = start;
	assign o_width         = cfg_width;

	// No stream word is taken between the last word and the end of the frame
	a_no_ready_in_crc: assert property (@(posedge i_clk) disable iff (i_reset)
		(take && i_s_last) |=> (!o_s_ready until (state == ST_IDLE)));

endmodule

// File: design/sdtx_pkg.sv
`include "sdtx_defines.svh"

package sdtx_pkg;

	// Bus width, held fixed for a whole frame
	typedef enum logic {
		BUS_1W = 1'b0,
		BUS_4W = 1'b1
	} bus_width_t;

	// One stream word, seen as serial bits for a single line
	// or as nibbles with one bit per data line
	typedef union packed {
		logic [`SDTX_WORD_W-1:0] bits;
		logic [`SDTX_WORD_W/`SDTX_LANES-1:0][`SDTX_LANES-1:0] nib;
	} sd_word_t;

	// Framer to CRC controls
	typedef struct packed {
		logic load;
		logic shift;
		logic clear;
	} crc_ctl_t;

	// Framer to serializer word
	typedef struct packed {
		logic     valid;
		sd_word_t data;
		logic     short;
		logic     start;
	} tx_word_t;

endpackage

// File: design/sdtx_defines.svh
`ifndef SDTX_DEFINES_SVH
`define SDTX_DEFINES_SVH

// CRC16 carried on every SD data line
`define SDTX_CRC_W	16
`define SDTX_CRC_POLY	16'h1021

// Stream word and bus geometry
`define SDTX_WORD_W	32
`define SDTX_LANES	4

// Strobes per word, by width
`define SDTX_SYM_1W	32
`define SDTX_SYM_4W	8
// One-line CRC fills only half a word
`define SDTX_SYM_CRC1W	16

`endif
